// File: Bender.yml
package:
  name: compute_pipeline

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/compute_pkg.sv
      - verilog/issue_control.sv
      - dot_lane/dot_lane.sv
      - verilog/memory_port.sv
      - verilog/compute_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/compute_assertions.sv
      - verification/compute_tb.sv

// File: common/compute_cfg.svh
/*
 * Build constants of the compute pipeline: memory address width and
 * read latency, coefficient bank depth, lane count, accumulator width
 * and the fixed pipeline depths.
 */
`ifndef COMPUTE_CFG_SVH
`define COMPUTE_CFG_SVH

// Word address of the 64-bit external memory.
`define MEM_ADDR_W 16
// Cycles from the ren cycle to the cycle with valid rdata.
`define MEM_READ_LATENCY 2
// Coefficient rows held by each lane.
`define COEFF_DEPTH 512
`define LANES 2
`define ACC_W 32
// Cycles from lane_ctrl to the accumulator update.
`define LANE_DEPTH 5
// Cycles from command acceptance to the write cycle.
`define WB_LATENCY 9

`endif

// File: common/compute_pkg.sv
/*
 * Shared types of the compute pipeline: instruction word, opcode names,
 * the 64-bit memory word, memory requests, lane and write-back controls
 * and lane results.
 */
`include "compute_cfg.svh"

package compute_pkg;

	typedef enum logic [5:0] {
		OP_LOAD_COEFF0 = 6'd5,
		OP_LOAD_COEFF1 = 6'd6,
		OP_STORE       = 6'd16,
		OP_RELU        = 6'd20,
		OP_SAVE        = 6'd24,
		OP_LD_SET      = 6'd28,
		OP_MACC        = 6'd40,
		OP_MACCZ       = 6'd42
	} opcode_e;

	typedef struct packed {
		logic [16:0] maddr;			// Memory word address.
		logic [$clog2(`COEFF_DEPTH)-1:0] caddr;	// Coefficient row or shift.
		logic [5:0]  opcode;
	} insn_t;

	typedef logic signed [7:0] sbyte_t;

	// MACC and LoadCoeff see bytes, LdSet and Save see words.
	typedef union packed {
		sbyte_t [7:0]     bytes;
		logic [1:0][31:0] words;
	} mem_word_u;

	typedef struct packed {
		logic                   ren;
		logic [7:0]             wen;	// Byte enables.
		logic [`MEM_ADDR_W-1:0] addr;
		mem_word_u              wdata;
	} mem_req_t;

	typedef struct packed {
		logic                            en;
		logic [`LANES-1:0]               load_coeff;	// One bit per lane.
		logic                            macc;
		logic                            clear;		// MACCZ drops the old sum.
		logic                            ld_set;
		logic [$clog2(`COEFF_DEPTH)-1:0] caddr;
		logic [4:0]                      shift;
	} lane_ctrl_t;

	typedef struct packed {
		logic [`ACC_W-1:0] acc;
		logic [7:0]        sat_byte;
	} lane_result_t;

	typedef struct packed {
		logic                   store;
		logic                   relu;
		logic                   save;
		logic [`MEM_ADDR_W-1:0] addr;
	} wb_ctrl_t;

endpackage

// File: dot_lane/dot_lane.sv
/*
 * One accumulator lane: coefficient bank, three-stage signed 8x8
 * multiplier, product sum, accumulator and the shifted, saturated
 * output byte.
 */
`timescale 1ns/1ps
`include "compute_cfg.svh"

module dot_lane #(
	parameter int lane_index = 0
) (
	input  logic                   clock,
	input  logic                   reset,
	input  compute_pkg::lane_ctrl_t lane_ctrl,
	input  compute_pkg::mem_word_u  mem_rdata,
	output compute_pkg::lane_result_t result
);
	import compute_pkg::*;

	localparam int acc_stage = `LANE_DEPTH - 1;

	mem_word_u                coeff_bank [`COEFF_DEPTH];
	lane_ctrl_t               ctrl_q [1:acc_stage];	// Controls beside the datapath.
	mem_word_u                data_q;
	mem_word_u                coeff_q;
	logic signed [15:0]       prod_q [8];
	logic signed [15:0]       prod_qq [8];
	logic [31:0]              word_q2;
	logic [31:0]              word_q3;
	logic signed [`ACC_W-1:0] prod_total;
	logic signed [`ACC_W-1:0] sum_q;
	logic signed [`ACC_W-1:0] acc;
	logic signed [`ACC_W-1:0] shifted;
	logic [7:0]               sat_q;

	// Coefficient write and the row read share the lane_ctrl cycle.
	always_ff @(posedge clock) begin
		if (lane_ctrl.en && lane_ctrl.load_coeff[lane_index]) begin
			coeff_bank[lane_ctrl.caddr] <= mem_rdata;
		end
		coeff_q <= coeff_bank[lane_ctrl.caddr];
		data_q <= mem_rdata;	// Stage 1 operands.
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i <= acc_stage; i++) begin
				ctrl_q[i] <= '0;
			end
		end else begin
			ctrl_q[1] <= lane_ctrl;
			for (int i = 2; i <= acc_stage; i++) begin
				ctrl_q[i] <= ctrl_q[i-1];
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < 8; i++) begin
			prod_q[i] <= $signed(data_q.bytes[i]) * $signed(coeff_q.bytes[i]);	// Stage 2.
			prod_qq[i] <= prod_q[i];	// Stage 3.
		end
		word_q2 <= data_q.words[lane_index];	// This lane's half of LdSet.
		word_q3 <= word_q2;
	end

	always_comb begin
		prod_total = '0;
		for (int i = 0; i < 8; i++) begin
			prod_total = prod_total + prod_qq[i];
		end
	end

	always_ff @(posedge clock) begin
		sum_q <= ctrl_q[acc_stage-1].ld_set ? word_q3 : prod_total;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			acc <= '0;
		end else if (ctrl_q[acc_stage].en
				&& (ctrl_q[acc_stage].macc || ctrl_q[acc_stage].ld_set)) begin
			// MACCZ and LdSet start from zero, MACC keeps adding.
			if (ctrl_q[acc_stage].clear || ctrl_q[acc_stage].ld_set) begin
				acc <= sum_q;
			end else begin
				acc <= acc + sum_q;	// Wraps at 32 bits.
			end
		end
	end

	// Shift comes with the instruction now at the accumulate stage.
	assign shifted = acc >>> ctrl_q[acc_stage].shift;

	always_ff @(posedge clock) begin
		if (shifted > 127) begin
			sat_q <= 8'h7f;
		end else if (shifted < -128) begin
			sat_q <= 8'h80;
		end else begin
			sat_q <= shifted[7:0];
		end
	end

	always_comb begin
		result.acc = acc;
		result.sat_byte = sat_q;
	end

endmodule

// File: sources.f
+incdir+common
common/compute_pkg.sv
verilog/issue_control.sv
dot_lane/dot_lane.sv
verilog/memory_port.sv
verilog/compute_top.sv
verification/compute_assertions.sv
verification/compute_tb.sv

// File: verification/compute_assertions.sv
/*
 * Concurrent checks on the memory bus and the command handshake,
 * bound into the compute pipeline top level.
 */
`timescale 1ns/1ps

module compute_assertions (
	input logic                  clock,
	input logic                  reset,
	input logic                  cmd_valid,
	input logic                  cmd_ready,
	input compute_pkg::insn_t    cmd_insn,
	input compute_pkg::mem_req_t mem_req,
	input logic                  busy
);
	int failures = 0;

	// Reads and writes share one address bus.
	bus_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(mem_req.ren && |mem_req.wen))
		else begin
			$error("ren and wen high in the same cycle");
			failures++;
		end

	idle_bus: assert property (@(posedge clock) disable iff (reset)
		!busy |-> !mem_req.ren && mem_req.wen == '0)
		else begin
			$error("memory access while busy is low");
			failures++;
		end

	held_command: assert property (@(posedge clock) disable iff (reset)
		cmd_valid && !cmd_ready |=> $stable(cmd_insn))
		else begin
			$error("cmd_insn changed while waiting for cmd_ready");
			failures++;
		end

endmodule

bind compute_top compute_assertions bus_checks (
	.clock     (clock),
	.reset     (reset),
	.cmd_valid (cmd_valid),
	.cmd_ready (cmd_ready),
	.cmd_insn  (cmd_insn),
	.mem_req   (mem_req),
	.busy      (busy)
);

// File: verification/compute_tb.sv
/*
 * Compute pipeline testbench: clock and reset, memory model with a fixed
 * read latency, reference model of coefficients, accumulators and memory,
 * random stimulus and the result checks.
 */
`timescale 1ns/1ps
`include "compute_cfg.svh"

module compute_tb;
	import compute_pkg::*;

	localparam int timeout = 40;

	logic      clock;
	logic      reset;
	logic      cmd_valid;
	logic      cmd_ready;
	insn_t     cmd_insn;
	mem_req_t  mem_req;
	mem_word_u mem_rdata;
	logic      busy;

	int                     seed = 26369;
	int                     cycle = 0;
	int                     errors = 0;
	int                     passed = 0;
	int                     failed = 0;
	int                     next_addr = 0;	// Read data lives below 16'h8000.
	logic [63:0]            mem [65536];
	mem_word_u              rd_pipe [1:`MEM_READ_LATENCY-1];
	mem_word_u              coeff [2][`COEFF_DEPTH];
	logic signed [31:0]     acc_m [2];
	int                     rows [$];
	int                     wr_cycle_q [$];	// Write beats seen on the bus.
	mem_req_t               wr_req_q [$];
	int                     exp_accept_q [$];	// Writes the model expects.
	logic [`MEM_ADDR_W-1:0] exp_addr_q [$];
	mem_word_u              exp_data_q [$];
	logic                   exp_save_q [$];
	opcode_e                write_ops [3] = '{OP_STORE, OP_RELU, OP_SAVE};

	compute_top DUT (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock)
		cycle <= cycle + 1;

	// Memory model. Only a read returns data, byte enables select the written bytes.
	always @(posedge clock) begin
		mem_word_u out;
		out = rd_pipe[`MEM_READ_LATENCY-1];
		for (int i = `MEM_READ_LATENCY - 1; i > 1; i--)
			rd_pipe[i] = rd_pipe[i-1];
		rd_pipe[1] = mem_req.ren ? mem[mem_req.addr] : 'x;
		if (|mem_req.wen) begin
			for (int b = 0; b < 8; b++) begin
				if (mem_req.wen[b])
					mem[mem_req.addr][8*b +: 8] = mem_req.wdata.bytes[b];
			end
			wr_cycle_q.push_back(cycle);
			wr_req_q.push_back(mem_req);
		end
		#5;
		mem_rdata = out;
	end

	function automatic insn_t make_insn(input opcode_e op, input int maddr, input int caddr);
		insn_t insn;
		insn.maddr = maddr[16:0];
		insn.caddr = caddr[8:0];
		insn.opcode = op;
		return insn;
	endfunction

	function automatic int pick_row();
		return rows[($random(seed) & 32'h7fff) % rows.size()];
	endfunction

	// Signed byte-wise dot product of a data word and a coefficient row.
	function automatic logic signed [31:0] dot(input mem_word_u data, input mem_word_u row);
		logic signed [31:0] total;
		total = 0;
		for (int i = 0; i < 8; i++)
			total += data.bytes[i] * row.bytes[i];
		return total;
	endfunction

	function automatic logic [7:0] clamp(input logic signed [31:0] value, input int shift,
			input logic relu);
		logic signed [31:0] s;
		s = value >>> shift;
		if (s > 127)
			s = 127;
		else if (s < -128)
			s = -128;
		if (relu && s < 0)
			s = 0;
		return s[7:0];
	endfunction

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s is %b, expected %b", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic check_latency(input string what, input int expected, input int actual);
		if (actual != expected) begin
			$display("Error at %0t: %s is %0d cycles, expected %0d", $time, what, actual,
				expected);
			errors++;
		end
	endtask

	task automatic check_save(input mem_word_u expected, input logic [`MEM_ADDR_W-1:0] addr,
			input mem_req_t actual);
		if (actual.wdata !== expected || actual.wen !== 8'hff || actual.addr !== addr) begin
			$display("Error at %0t: Save wrote %h, wen %h, addr %h; expected %h at %h",
				$time, actual.wdata, actual.wen, actual.addr, expected, addr);
			errors++;
		end
	endtask

	task automatic check_store(input mem_word_u expected, input logic [`MEM_ADDR_W-1:0] addr,
			input mem_req_t actual);
		if (actual.wdata.bytes[1:0] !== expected.bytes[1:0] || actual.wen !== 8'h03
				|| actual.addr !== addr) begin
			$display("Error at %0t: Store wrote %h %h, wen %h, addr %h; expected %h %h at %h",
				$time, actual.wdata.bytes[1], actual.wdata.bytes[0], actual.wen,
				actual.addr, expected.bytes[1], expected.bytes[0], addr);
			errors++;
		end
	endtask

	task automatic wait_ready(output int rise);
		int waited;
		waited = 0;
		while (!cmd_ready && waited < timeout) begin
			@(posedge clock);
			#5;
			waited++;
		end
		if (!cmd_ready) begin
			$display("Timed out at %0t waiting for cmd_ready", $time);
			errors++;
		end
		rise = cycle;
	endtask

	// Holds valid and the instruction until the accepting edge.
	task automatic send(input insn_t insn, output int accepted);
		int rise;
		cmd_valid = 1'b1;
		cmd_insn = insn;
		wait_ready(rise);
		@(posedge clock);
		#5;
		accepted = cycle;
		cmd_valid = 1'b0;
	endtask

	task automatic read_op(input opcode_e op, input int row);
		mem_word_u data;
		int        addr;
		int        accepted;
		addr = next_addr;
		next_addr++;
		data.words[0] = $random(seed);
		data.words[1] = $random(seed);
		if (op == OP_LD_SET) begin
			// Narrow words also reach the unclamped range of Store.
			data.words[0] = $signed(data.words[0]) >>> ($random(seed) & 31);
			data.words[1] = $signed(data.words[1]) >>> ($random(seed) & 31);
		end
		mem[addr] = data;
		case (op)
			OP_LOAD_COEFF0: coeff[0][row] = data;
			OP_LOAD_COEFF1: coeff[1][row] = data;
			OP_LD_SET: begin
				acc_m[0] = data.words[0];
				acc_m[1] = data.words[1];
			end
			OP_MACCZ: begin
				acc_m[0] = dot(data, coeff[0][row]);
				acc_m[1] = dot(data, coeff[1][row]);
			end
			default: begin
				acc_m[0] += dot(data, coeff[0][row]);
				acc_m[1] += dot(data, coeff[1][row]);
			end
		endcase
		send(make_insn(op, addr, row), accepted);
	endtask

	task automatic write_op(input opcode_e op, input int shift, output int accepted);
		mem_word_u data;
		int        addr;
		data = '0;
		if (op == OP_SAVE) begin
			data.words[0] = acc_m[0];
			data.words[1] = acc_m[1];
		end else begin
			data.bytes[0] = clamp(acc_m[0], shift, op == OP_RELU);
			data.bytes[1] = clamp(acc_m[1], shift, op == OP_RELU);
		end
		addr = 32'h8000 | ($random(seed) & 32'h7fff);
		send(make_insn(op, addr, shift), accepted);
		exp_accept_q.push_back(accepted);
		exp_addr_q.push_back(addr[`MEM_ADDR_W-1:0]);
		exp_data_q.push_back(data);
		exp_save_q.push_back(op == OP_SAVE);
	endtask

	// Pairs every expected write with the next beat seen on the bus.
	task automatic drain_writes();
		int       waited;
		mem_req_t req;
		while (exp_accept_q.size() > 0) begin
			waited = 0;
			while (wr_cycle_q.size() == 0 && waited < timeout) begin
				@(posedge clock);
				#5;
				waited++;
			end
			if (wr_cycle_q.size() == 0) begin
				$display("Timed out at %0t waiting for a memory write", $time);
				errors++;
				exp_accept_q.delete();
				exp_addr_q.delete();
				exp_data_q.delete();
				exp_save_q.delete();
			end else begin
				check_latency("write latency", `WB_LATENCY,
					wr_cycle_q.pop_front() - exp_accept_q.pop_front());
				req = wr_req_q.pop_front();
				if (exp_save_q.pop_front())
					check_save(exp_data_q.pop_front(), exp_addr_q.pop_front(), req);
				else
					check_store(exp_data_q.pop_front(), exp_addr_q.pop_front(), req);
			end
		end
	endtask

	task automatic end_test(input string name, input int mark);
		if (errors == mark) begin
			passed++;
			$display("Test %s: ok", name);
		end else begin
			failed++;
			$display("Test %s: %0d errors", name, errors - mark);
		end
	endtask

	initial begin
		int mark;
		int accepted;
		int store_accept;
		int release_cycle;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd_insn = '0;
		mem_rdata = '0;
		for (int i = 0; i < 65536; i++)
			mem[i] = {16'(i), ~16'(i), 16'(i * 40503), 16'(i) ^ 16'h5a5a};
		repeat (10) @(posedge clock);
		#5;
		reset = 1'b0;

		mark = errors;
		check_flag("cmd_ready", 1'b1, cmd_ready);
		check_flag("busy", 1'b0, busy);
		check_flag("ren", 1'b0, mem_req.ren);
		check_flag("wen", 1'b0, |mem_req.wen);
		end_test("reset state", mark);

		mark = errors;
		for (int k = 0; k < 4; k++) begin
			rows.push_back($random(seed) & 511);
			read_op(OP_LOAD_COEFF0, rows[k]);
			read_op(OP_LOAD_COEFF1, rows[k]);
		end
		read_op(OP_MACCZ, pick_row());
		write_op(OP_SAVE, 0, accepted);
		drain_writes();
		end_test("coefficients and MACCZ", mark);

		mark = errors;
		read_op(OP_LD_SET, 0);
		for (int k = 0; k < 8; k++)
			read_op(OP_MACC, pick_row());
		write_op(OP_SAVE, 0, accepted);
		drain_writes();
		end_test("MACC accumulation", mark);

		mark = errors;
		for (int k = 0; k < 6; k++) begin
			read_op(OP_LD_SET, 0);
			write_op(OP_STORE, $random(seed) & 31, accepted);
			write_op(OP_RELU, $random(seed) & 31, accepted);
		end
		drain_writes();
		end_test("Store and ReLU", mark);

		mark = errors;
		write_op(OP_STORE, $random(seed) & 31, store_accept);
		read_op(OP_MACC, pick_row());
		check_flag("cmd_ready behind a stalled read", 1'b0, cmd_ready);
		check_flag("busy behind a stalled read", 1'b1, busy);
		wait_ready(release_cycle);
		check_latency("read hold after Store", `WB_LATENCY + 1, release_cycle - store_accept);
		for (int k = 0; k < 6; k++)
			write_op(write_ops[($random(seed) & 32'h7fff) % 3], $random(seed) & 31, accepted);
		drain_writes();
		check_flag("busy after the last write", 1'b0, busy);
		check_latency("extra writes", 0, wr_cycle_q.size());
		end_test("interlock and busy", mark);

		errors += DUT.bus_checks.failures;
		$display("Tests passed: %0d, failed: %0d, errors: %0d", passed, failed, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/compute_top.sv
/*
 * Compute pipeline top level: instruction sequencer, two accumulator
 * lanes and the memory port.
 */
`timescale 1ns/1ps

module compute_top (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  cmd_valid,
	output logic                  cmd_ready,
	input  compute_pkg::insn_t     cmd_insn,
	output compute_pkg::mem_req_t  mem_req,
	input  compute_pkg::mem_word_u mem_rdata,
	output logic                  busy
);
	import compute_pkg::*;

	mem_req_t     rd_req;
	lane_ctrl_t   lane_ctrl;	// Shared by both lanes.
	wb_ctrl_t     wb_ctrl;
	lane_result_t lane0_result;
	lane_result_t lane1_result;

	issue_control issue (
		.clock     (clock),
		.reset     (reset),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd_insn  (cmd_insn),
		.rd_req    (rd_req),
		.lane_ctrl (lane_ctrl),
		.wb_ctrl   (wb_ctrl),
		.busy      (busy)
	);

	dot_lane #(.lane_index(0)) lane0 (
		.clock     (clock),
		.reset     (reset),
		.lane_ctrl (lane_ctrl),
		.mem_rdata (mem_rdata),
		.result    (lane0_result)
	);

	dot_lane #(.lane_index(1)) lane1 (
		.clock     (clock),
		.reset     (reset),
		.lane_ctrl (lane_ctrl),
		.mem_rdata (mem_rdata),
		.result    (lane1_result)
	);

	memory_port mem_port (
		.clock        (clock),
		.reset        (reset),
		.rd_req       (rd_req),
		.wb_ctrl      (wb_ctrl),
		.lane0_result (lane0_result),
		.lane1_result (lane1_result),
		.mem_req      (mem_req)
	);

endmodule

// File: verilog/issue_control.sv
/*
 * Instruction sequencer: command acceptance into S1, opcode decode,
 * the read/write bus interlock, read requests and the control delay
 * lines that feed the lanes and the memory port.
 */
`timescale 1ns/1ps
`include "compute_cfg.svh"

module issue_control (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   cmd_valid,
	output logic                   cmd_ready,
	input  compute_pkg::insn_t      cmd_insn,
	output compute_pkg::mem_req_t   rd_req,
	output compute_pkg::lane_ctrl_t lane_ctrl,
	output compute_pkg::wb_ctrl_t   wb_ctrl,
	output logic                   busy
);
	import compute_pkg::*;

	localparam int ctrl_stage = 1 + `MEM_READ_LATENCY;	// Meets rdata.
	localparam int wb_stage = ctrl_stage + `LANE_DEPTH;	// One cycle ahead of wen.

	logic                   s1_valid;
	insn_t                  s1_insn;
	logic                   s1_is_read;
	logic                   s1_is_write;
	logic                   s1_stall;
	logic                   s1_go;
	lane_ctrl_t             s1_lane;
	wb_ctrl_t               s1_wb;
	logic                   rd_ren_q;
	logic [`MEM_ADDR_W-1:0] rd_addr_q;
	logic [1:wb_stage]      valid_sr;
	logic [1:`WB_LATENCY]   wr_sr;		// Writes in flight up to the wen cycle.
	lane_ctrl_t             lane_sr [1:ctrl_stage];
	wb_ctrl_t               wb_sr [1:wb_stage];

	always_comb begin
		s1_is_read = 1'b0;
		s1_is_write = 1'b0;
		s1_lane = '0;
		s1_wb = '0;
		s1_lane.en = 1'b1;
		s1_lane.caddr = s1_insn.caddr;
		s1_lane.shift = s1_insn.caddr[4:0];
		s1_wb.addr = s1_insn.maddr[`MEM_ADDR_W-1:0];
		case (s1_insn.opcode)
			OP_LOAD_COEFF0: begin
				s1_is_read = 1'b1;
				s1_lane.load_coeff[0] = 1'b1;
			end
			OP_LOAD_COEFF1: begin
				s1_is_read = 1'b1;
				s1_lane.load_coeff[1] = 1'b1;
			end
			OP_LD_SET: begin
				s1_is_read = 1'b1;
				s1_lane.ld_set = 1'b1;
			end
			OP_MACC: begin
				s1_is_read = 1'b1;
				s1_lane.macc = 1'b1;
			end
			OP_MACCZ: begin
				s1_is_read = 1'b1;
				s1_lane.macc = 1'b1;
				s1_lane.clear = 1'b1;
			end
			OP_STORE: begin
				s1_is_write = 1'b1;
				s1_wb.store = 1'b1;
			end
			OP_RELU: begin
				s1_is_write = 1'b1;
				s1_wb.relu = 1'b1;
			end
			OP_SAVE: begin
				s1_is_write = 1'b1;
				s1_wb.save = 1'b1;
			end
			default: s1_is_read = 1'b0;	// Unknown opcodes flow as bubbles.
		endcase
		// A read waits until no write is left to meet it on the bus.
		s1_stall = s1_valid && s1_is_read && |wr_sr;
		s1_go = s1_valid && !s1_stall;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			s1_valid <= 1'b0;
		end else if (!s1_stall) begin
			s1_valid <= cmd_valid;
		end
		if (!s1_stall) begin
			s1_insn <= cmd_insn;
		end
	end

	always_ff @(posedge clock) begin
		rd_addr_q <= s1_insn.maddr[`MEM_ADDR_W-1:0];
		if (reset) begin
			rd_ren_q <= 1'b0;
			valid_sr <= '0;
			wr_sr <= '0;
			for (int i = 1; i <= ctrl_stage; i++) begin
				lane_sr[i] <= '0;
			end
			for (int i = 1; i <= wb_stage; i++) begin
				wb_sr[i] <= '0;
			end
		end else begin
			rd_ren_q <= s1_go && s1_is_read;
			valid_sr <= {s1_go, valid_sr[1:wb_stage-1]};
			wr_sr <= {s1_go && s1_is_write, wr_sr[1:`WB_LATENCY-1]};
			lane_sr[1] <= s1_go ? s1_lane : '0;
			wb_sr[1] <= s1_go ? s1_wb : '0;
			for (int i = 2; i <= ctrl_stage; i++) begin
				lane_sr[i] <= lane_sr[i-1];
			end
			for (int i = 2; i <= wb_stage; i++) begin
				wb_sr[i] <= wb_sr[i-1];
			end
		end
	end

	always_comb begin
		rd_req = '0;
		rd_req.ren = rd_ren_q;
		rd_req.addr = rd_addr_q;
	end

	assign cmd_ready = !s1_stall;
	assign lane_ctrl = lane_sr[ctrl_stage];
	assign wb_ctrl = wb_sr[wb_stage];
	assign busy = s1_valid || |valid_sr || |wr_sr;

endmodule

// File: verilog/memory_port.sv
/*
 * Memory port: builds Store, ReLU and Save beats from the lane results,
 * registers them and merges them with the read requests.
 */
`timescale 1ns/1ps

module memory_port (
	input  logic                     clock,
	input  logic                     reset,
	input  compute_pkg::mem_req_t     rd_req,
	input  compute_pkg::wb_ctrl_t     wb_ctrl,
	input  compute_pkg::lane_result_t lane0_result,
	input  compute_pkg::lane_result_t lane1_result,
	output compute_pkg::mem_req_t     mem_req
);
	import compute_pkg::*;

	logic [7:0] byte0;
	logic [7:0] byte1;
	mem_word_u  beat_data;
	logic [7:0] beat_en;
	logic [7:0] wr_en_q;
	logic [15:0] wr_addr_q;
	mem_word_u  wr_data_q;

	always_comb begin
		byte0 = lane0_result.sat_byte;
		byte1 = lane1_result.sat_byte;
		if (wb_ctrl.relu && byte0[7]) begin
			byte0 = '0;
		end
		if (wb_ctrl.relu && byte1[7]) begin
			byte1 = '0;
		end
		beat_data = '0;
		beat_en = '0;
		if (wb_ctrl.save) begin
			beat_data.words[0] = lane0_result.acc;
			beat_data.words[1] = lane1_result.acc;
			beat_en = 8'hff;
		end else if (wb_ctrl.store || wb_ctrl.relu) begin
			beat_data.bytes[0] = byte0;	// Lane 0 lands in byte 0.
			beat_data.bytes[1] = byte1;
			beat_en = 8'h03;
		end
	end

	always_ff @(posedge clock) begin
		wr_addr_q <= wb_ctrl.addr;
		wr_data_q <= beat_data;
		if (reset) begin
			wr_en_q <= '0;
		end else begin
			wr_en_q <= beat_en;
		end
	end

	// Reads and writes never share a cycle, so the address is a plain select.
	always_comb begin
		mem_req = rd_req;
		mem_req.wen = rd_req.wen | wr_en_q;
		mem_req.wdata = wr_data_q;
		if (|wr_en_q) begin
			mem_req.addr = wr_addr_q;
		end
	end

endmodule
